//--- Bender.yml
package:
  name: board_io

sources:
  - include_dirs:
      - .
    files:
      - board_io_pkg.sv
      - pad_cell.sv
      - jtag_overlay_mux.sv
      - usb_swap_mux.sv
      - board_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_board_io.sv

//--- board_io_defines.svh
////////////////////////////////////////
// Board I/O layer constants
// Pad counts, tie-off masks and pad indices
////////////////////////////////////////

`ifndef BOARD_IO_DEFINES_SVH
`define BOARD_IO_DEFINES_SVH

// Pad counts
`define BOARD_IO_NUM_MIO 32
`define BOARD_IO_NUM_DIO 15
`define BOARD_IO_NUM_PADS 47

// Input synchronizer depth
`define BOARD_IO_SYNC_STAGES 2

// Connected pads, MIO 23..20 are not bonded out
`define BOARD_IO_MIO_CONNECT 32'hFF0F_FFFF
// DIO 2, 3, 4 and 7 are tied off
`define BOARD_IO_DIO_CONNECT 15'h7F63

// MIO pad indices
`define BOARD_IO_MIO_USE_UPHY 2
`define BOARD_IO_MIO_JTAG_EN 16
`define BOARD_IO_MIO_TRST 18
`define BOARD_IO_MIO_SRST 19

// DIO pad indices, USB device
`define BOARD_IO_DIO_USB_DN 0
`define BOARD_IO_DIO_USB_DP 1
`define BOARD_IO_DIO_USB_D 2
`define BOARD_IO_DIO_USB_DN_PULLUP 5
`define BOARD_IO_DIO_USB_DP_PULLUP 6
`define BOARD_IO_DIO_USB_SENSE 8

// DIO pad indices, SPI device
`define BOARD_IO_DIO_SPI_SDO 11
`define BOARD_IO_DIO_SPI_SDI 12
`define BOARD_IO_DIO_SPI_CSB 13
`define BOARD_IO_DIO_SPI_SCK 14

`endif

//--- board_io_pkg.sv
////////////////////////////////////////
// Board I/O types
// Pad drive bundles, pad attributes, JTAG and USB PHY ports
////////////////////////////////////////

`include "board_io_defines.svh"

package board_io_pkg;

  ////////////////////////////////////////
  // Pad side
  ////////////////////////////////////////

  // Out and output enable for every pad, MIO in the low 32 bits
  typedef struct packed {
    logic [`BOARD_IO_NUM_PADS-1:0] out;
    logic [`BOARD_IO_NUM_PADS-1:0] oe;
  } pad_drive_t;

  // Attributes of a single pad
  typedef struct packed {
    // Inverts the pad in both directions
    logic invert;
    // Drive only when the pad value is low
    logic open_drain;
  } pad_attr_bits_t;

  // Attributes of all pads, two bits per pad
  typedef struct packed {
    pad_attr_bits_t [`BOARD_IO_NUM_PADS-1:0] pad;
  } pad_attr_t;

  ////////////////////////////////////////
  // Debug and PHY side
  ////////////////////////////////////////

  // JTAG signals taken over from the pads
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
    logic srst_n;
  } jtag_port_t;

  // Receive path of the external USB PHY
  typedef struct packed {
    logic dp;
    logic dn;
    logic d;
    logic sense;
  } uphy_rx_t;

endpackage

//--- board_io_top.sv
////////////////////////////////////////
// Board I/O top level
// USB swap, JTAG overlay and the pad cells
////////////////////////////////////////

`timescale 1ns/1ps

`include "board_io_defines.svh"

module board_io_top (
  input  logic                            clk_main_i,
  input  logic                            rst_i,
  // Core side
  input  board_io_pkg::pad_drive_t        core_drive_i,
  input  board_io_pkg::pad_attr_t         core_attr_i,
  output logic [`BOARD_IO_NUM_PADS-1:0]   core_in_o,
  // Pad side
  input  logic [`BOARD_IO_NUM_PADS-1:0]   pad_in_i,
  output logic [`BOARD_IO_NUM_PADS-1:0]   pad_out_o,
  output logic [`BOARD_IO_NUM_PADS-1:0]   pad_oe_o,
  // Debug port
  output board_io_pkg::jtag_port_t        jtag_o,
  input  logic                            jtag_tdo_i,
  // External USB PHY
  input  board_io_pkg::uphy_rx_t          uphy_rx_i,
  output logic                            uphy_dp_tx_o,
  output logic                            uphy_dn_tx_o,
  output logic                            uphy_oe_n_o,
  output logic                            uphy_dppullup_o
);

  import board_io_pkg::*;

  // DIOs sit above the MIOs
  localparam logic [`BOARD_IO_NUM_PADS-1:0] ConnectMask = {
    `BOARD_IO_DIO_CONNECT,
    `BOARD_IO_MIO_CONNECT
  };

  // Core <- USB swap <- JTAG overlay <- pad cells
  pad_drive_t                    swap_drive;
  pad_drive_t                    pad_drive;
  logic [`BOARD_IO_NUM_PADS-1:0] overlay_in;
  logic [`BOARD_IO_NUM_PADS-1:0] sync_in;

  ////////////////////////////////////////
  // USB pin flip
  ////////////////////////////////////////

  usb_swap_mux u_usb_swap_mux (
    .clk_main_i      ( clk_main_i      ),
    .rst_i           ( rst_i           ),
    .core_drive_i    ( core_drive_i    ),
    .core_in_o       ( core_in_o       ),
    .drive_o         ( swap_drive      ),
    .overlay_in_i    ( overlay_in      ),
    .uphy_rx_i       ( uphy_rx_i       ),
    .uphy_dp_tx_o    ( uphy_dp_tx_o    ),
    .uphy_dn_tx_o    ( uphy_dn_tx_o    ),
    .uphy_oe_n_o     ( uphy_oe_n_o     ),
    .uphy_dppullup_o ( uphy_dppullup_o )
  );

  ////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////

  jtag_overlay_mux u_jtag_overlay_mux (
    .drive_i      ( swap_drive ),
    .overlay_in_o ( overlay_in ),
    .drive_o      ( pad_drive  ),
    .sync_in_i    ( sync_in    ),
    .jtag_o       ( jtag_o     ),
    .jtag_tdo_i   ( jtag_tdo_i )
  );

  ////////////////////////////////////////
  // Pad cells
  ////////////////////////////////////////

  for (genvar p = 0; p < `BOARD_IO_NUM_PADS; p++) begin : gen_pad
    pad_cell #(
      .Connected ( ConnectMask[p] )
    ) u_pad_cell (
      .clk_main_i  ( clk_main_i           ),
      .rst_i       ( rst_i                ),
      .drive_out_i ( pad_drive.out[p]     ),
      .drive_oe_i  ( pad_drive.oe[p]      ),
      .attr_i      ( core_attr_i.pad[p]   ),
      .sync_in_o   ( sync_in[p]           ),
      .pad_in_i    ( pad_in_i[p]          ),
      .pad_out_o   ( pad_out_o[p]         ),
      .pad_oe_o    ( pad_oe_o[p]          )
    );
  end

endmodule

//--- filelist.f
+incdir+.
board_io_pkg.sv
pad_cell.sv
jtag_overlay_mux.sv
usb_swap_mux.sv
board_io_top.sv
tb_board_io.sv

//--- jtag_overlay_mux.sv
////////////////////////////////////////
// JTAG overlay mux
// Hands the JTAG pads to the debug port while the strap is high
////////////////////////////////////////

`timescale 1ns/1ps

`include "board_io_defines.svh"

module jtag_overlay_mux (
  // From the USB swap mux
  input  board_io_pkg::pad_drive_t        drive_i,
  output logic [`BOARD_IO_NUM_PADS-1:0]   overlay_in_o,
  // To the pad cells
  output board_io_pkg::pad_drive_t        drive_o,
  input  logic [`BOARD_IO_NUM_PADS-1:0]   sync_in_i,
  // Debug port
  output board_io_pkg::jtag_port_t        jtag_o,
  input  logic                            jtag_tdo_i
);

  import board_io_pkg::*;

  localparam int NumPads = `BOARD_IO_NUM_PADS;

  // JTAG pads in the combined pad index space
  localparam int TckIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SCK;
  localparam int TmsIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_CSB;
  localparam int TdiIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SDI;
  localparam int TdoIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SDO;
  localparam int TrstIdx = `BOARD_IO_MIO_TRST;
  localparam int SrstIdx = `BOARD_IO_MIO_SRST;

  // Pads taken away from the core while JTAG is active
  localparam logic [NumPads-1:0] JtagMask = (NumPads'(1) << TckIdx)
                                          | (NumPads'(1) << TmsIdx)
                                          | (NumPads'(1) << TdiIdx)
                                          | (NumPads'(1) << TdoIdx)
                                          | (NumPads'(1) << TrstIdx)
                                          | (NumPads'(1) << SrstIdx);

  // SPI CSB is active low, so it idles high towards the core
  localparam logic [NumPads-1:0] TieOffValues = NumPads'(1) << TmsIdx;

  logic       jtag_en;
  jtag_port_t jtag_pads;

  // Strap comes from the synchronized pad
  assign jtag_en = sync_in_i[`BOARD_IO_MIO_JTAG_EN];

  assign jtag_pads = '{
    tck:    sync_in_i[TckIdx],
    tms:    sync_in_i[TmsIdx],
    tdi:    sync_in_i[TdiIdx],
    trst_n: sync_in_i[TrstIdx],
    srst_n: sync_in_i[SrstIdx]
  };

  assign jtag_o = jtag_en ? jtag_pads : '0;

  ////////////////////////////////////////
  // Pad overlay
  ////////////////////////////////////////

  always_comb begin
    drive_o      = drive_i;
    overlay_in_o = sync_in_i;
    if (jtag_en) begin
      // Release the stolen pads, then drive TDO
      drive_o.out         = drive_i.out & ~JtagMask;
      drive_o.oe          = drive_i.oe & ~JtagMask;
      drive_o.out[TdoIdx] = jtag_tdo_i;
      drive_o.oe[TdoIdx]  = 1'b1;
      // Core sees idle values on the stolen pads
      overlay_in_o = (sync_in_i & ~JtagMask) | TieOffValues;
    end
  end

endmodule

//--- pad_cell.sv
////////////////////////////////////////
// Pad cell
// Applies pad attributes, synchronizes the pad input
////////////////////////////////////////

`timescale 1ns/1ps

`include "board_io_defines.svh"

module pad_cell #(
  // Cleared for pads that are not bonded out
  parameter bit Connected = 1'b1
) (
  input  logic                          clk_main_i,
  input  logic                          rst_i,
  // Core side
  input  logic                          drive_out_i,
  input  logic                          drive_oe_i,
  input  board_io_pkg::pad_attr_bits_t  attr_i,
  output logic                          sync_in_o,
  // Pad side
  input  logic                          pad_in_i,
  output logic                          pad_out_o,
  output logic                          pad_oe_o
);

  localparam int SyncStages = `BOARD_IO_SYNC_STAGES;

  logic                  out_inv;
  logic                  in_inv;
  logic [SyncStages-1:0] sync_q;

  ////////////////////////////////////////
  // Drive path
  ////////////////////////////////////////

  assign out_inv = drive_out_i ^ attr_i.invert;

  // Open drain only pulls low, a high value floats the pad
  assign pad_out_o = Connected & out_inv;
  assign pad_oe_o  = Connected & drive_oe_i & ~(attr_i.open_drain & out_inv);

  ////////////////////////////////////////
  // Input path
  ////////////////////////////////////////

  // Unconnected pads read back as 0
  assign in_inv = Connected & (pad_in_i ^ attr_i.invert);

  // Two flop synchronizer, pad input is asynchronous
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], in_inv};
    end
  end

  assign sync_in_o = sync_q[SyncStages-1];

endmodule

//--- tb_board_io.sv
////////////////////////////////////////
// Board I/O testbench
// Table driven checks of pad, JTAG and USB paths
////////////////////////////////////////

`timescale 1ns/1ps

`include "board_io_defines.svh"

module tb_board_io;

  import board_io_pkg::*;

  localparam int NumPads    = `BOARD_IO_NUM_PADS;
  localparam int NumEntries = 32;
  localparam int CycleLimit = NumEntries * 4 + 20;

  localparam int UsbDn   = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DN;
  localparam int UsbDp   = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DP;
  localparam int UsbD    = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_D;
  localparam int UsbDnPu = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DN_PULLUP;
  localparam int UsbDpPu = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DP_PULLUP;
  localparam int UsbSns  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_SENSE;
  localparam int SpiSdo  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SDO;
  localparam int SpiSdi  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SDI;
  localparam int SpiCsb  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_CSB;
  localparam int SpiSck  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_SPI_SCK;
  localparam logic [NumPads-1:0] ConnectMask = {`BOARD_IO_DIO_CONNECT, `BOARD_IO_MIO_CONNECT};

  typedef struct packed {
    pad_drive_t           drive;
    pad_attr_t            attr;
    logic [NumPads-1:0]   pad_in;
    uphy_rx_t             uphy_rx;
    logic                 tdo;
  } stim_t;

  // uphy_tx holds dp, dn, oe_n and dppullup
  typedef struct packed {
    logic [NumPads-1:0] pad_out;
    logic [NumPads-1:0] pad_oe;
    logic [NumPads-1:0] core_in;
    jtag_port_t         jtag;
    logic [3:0]         uphy_tx;
  } expect_t;

  typedef struct packed {
    stim_t   stim;
    expect_t exp_now;
    expect_t exp_settled;
  } entry_t;

  logic               clk_main_i;
  logic               rst_i;
  pad_drive_t         core_drive_i;
  pad_attr_t          core_attr_i;
  logic [NumPads-1:0] core_in_o;
  logic [NumPads-1:0] pad_in_i;
  logic [NumPads-1:0] pad_out_o;
  logic [NumPads-1:0] pad_oe_o;
  jtag_port_t         jtag_o;
  logic               jtag_tdo_i;
  uphy_rx_t           uphy_rx_i;
  logic               uphy_dp_tx_o;
  logic               uphy_dn_tx_o;
  logic               uphy_oe_n_o;
  logic               uphy_dppullup_o;

  entry_t      table_q [NumEntries];
  logic [31:0] lcg_state = 32'd30;
  int          cycle_count = 0;
  int          cur_entry = -1;

  board_io_top UUT (
    .clk_main_i      ( clk_main_i      ),
    .rst_i           ( rst_i           ),
    .core_drive_i    ( core_drive_i    ),
    .core_attr_i     ( core_attr_i     ),
    .core_in_o       ( core_in_o       ),
    .pad_in_i        ( pad_in_i        ),
    .pad_out_o       ( pad_out_o       ),
    .pad_oe_o        ( pad_oe_o        ),
    .jtag_o          ( jtag_o          ),
    .jtag_tdo_i      ( jtag_tdo_i      ),
    .uphy_rx_i       ( uphy_rx_i       ),
    .uphy_dp_tx_o    ( uphy_dp_tx_o    ),
    .uphy_dn_tx_o    ( uphy_dn_tx_o    ),
    .uphy_oe_n_o     ( uphy_oe_n_o     ),
    .uphy_dppullup_o ( uphy_dppullup_o )
  );

  initial begin
    clk_main_i = 1'b0;
    forever #4 clk_main_i = ~clk_main_i;
  end

  always @(posedge clk_main_i) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      $display("Timeout, the run did not finish within %0d cycles", CycleLimit);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
    end
  end

  ////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////

  // Upper half of the LCG state, the low bits cycle too fast
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic logic [NumPads-1:0] rand_pads();
    logic [47:0] r;
    r = {lcg_next(), lcg_next(), lcg_next()};
    return r[NumPads-1:0];
  endfunction

  function automatic bit is_jtag_pad(input int p);
    return p == SpiSck || p == SpiCsb || p == SpiSdi || p == SpiSdo ||
           p == `BOARD_IO_MIO_TRST || p == `BOARD_IO_MIO_SRST;
  endfunction

  // Strap value as the pad cell sees it
  function automatic logic strap_of(input stim_t s);
    return s.pad_in[`BOARD_IO_MIO_JTAG_EN] ^ s.attr.pad[`BOARD_IO_MIO_JTAG_EN].invert;
  endfunction

  function automatic expect_t model_io(input stim_t s, input logic drive_strap);
    logic [NumPads-1:0] sw_out;
    logic [NumPads-1:0] sw_oe;
    logic [NumPads-1:0] pad_sync;
    logic [NumPads-1:0] ov_in;
    logic               undo;
    logic               bit_out;
    uphy_rx_t           rx;
    expect_t            e;
    e = '0;
    sw_out = s.drive.out;
    sw_oe  = s.drive.oe;
    undo   = s.drive.oe[UsbDnPu];
    if (undo) begin
      sw_out[UsbDn]   = s.drive.out[UsbDp];
      sw_oe[UsbDn]    = s.drive.oe[UsbDp];
      sw_out[UsbDp]   = s.drive.out[UsbDn];
      sw_oe[UsbDp]    = s.drive.oe[UsbDn];
      sw_out[UsbDnPu] = s.drive.out[UsbDpPu];
      sw_oe[UsbDnPu]  = s.drive.oe[UsbDpPu];
      sw_out[UsbDpPu] = s.drive.out[UsbDnPu];
      sw_oe[UsbDpPu]  = s.drive.oe[UsbDnPu];
      sw_out[UsbD]    = ~s.drive.out[UsbD];
    end
    e.uphy_tx = {sw_out[UsbDp], sw_out[UsbDn], ~sw_oe[UsbDp], sw_out[UsbDpPu] & sw_oe[UsbDpPu]};
    // Debug port owns the JTAG pads
    if (drive_strap) begin
      for (int p = 0; p < NumPads; p++) begin
        if (is_jtag_pad(p)) begin
          sw_out[p] = 1'b0;
          sw_oe[p]  = 1'b0;
        end
      end
      sw_out[SpiSdo] = s.tdo;
      sw_oe[SpiSdo]  = 1'b1;
    end
    for (int p = 0; p < NumPads; p++) begin
      bit_out        = sw_out[p] ^ s.attr.pad[p].invert;
      e.pad_out[p]   = ConnectMask[p] & bit_out;
      e.pad_oe[p]    = ConnectMask[p] & sw_oe[p] & ~(s.attr.pad[p].open_drain & bit_out);
      pad_sync[p]    = ConnectMask[p] & (s.pad_in[p] ^ s.attr.pad[p].invert);
    end
    ov_in = pad_sync;
    if (pad_sync[`BOARD_IO_MIO_JTAG_EN]) begin
      e.jtag.tck    = pad_sync[SpiSck];
      e.jtag.tms    = pad_sync[SpiCsb];
      e.jtag.tdi    = pad_sync[SpiSdi];
      e.jtag.trst_n = pad_sync[`BOARD_IO_MIO_TRST];
      e.jtag.srst_n = pad_sync[`BOARD_IO_MIO_SRST];
      for (int p = 0; p < NumPads; p++) begin
        if (is_jtag_pad(p)) ov_in[p] = (p == SpiCsb);
      end
    end
    if (ov_in[`BOARD_IO_MIO_USE_UPHY]) begin
      rx = s.uphy_rx;
    end else begin
      rx = '{dp: ov_in[UsbDp], dn: ov_in[UsbDn], d: ov_in[UsbD], sense: ov_in[UsbSns]};
    end
    e.core_in         = ov_in;
    e.core_in[UsbDn]  = undo ? rx.dp : rx.dn;
    e.core_in[UsbDp]  = undo ? rx.dn : rx.dp;
    e.core_in[UsbD]   = undo ? ~rx.d : rx.d;
    e.core_in[UsbSns] = rx.sense;
    return e;
  endfunction

  // 20 pad cell entries, then 4 each for JTAG, USB swap and external PHY
  task automatic build_table();
    stim_t       s;
    logic        prev_strap;
    logic [15:0] r;
    prev_strap = 1'b0;
    for (int i = 0; i < NumEntries; i++) begin
      s.drive.out = rand_pads();
      s.drive.oe  = rand_pads();
      s.attr      = {rand_pads(), rand_pads()};
      s.pad_in    = rand_pads();
      r           = lcg_next();
      s.uphy_rx   = r[15:12];
      s.tdo       = r[11];
      s.drive.oe[UsbDnPu] = 1'b0;
      if (i < 20) begin
        // Strap and PHY switch read back as 0
        s.pad_in[`BOARD_IO_MIO_JTAG_EN]  = s.attr.pad[`BOARD_IO_MIO_JTAG_EN].invert;
        s.pad_in[`BOARD_IO_MIO_USE_UPHY] = s.attr.pad[`BOARD_IO_MIO_USE_UPHY].invert;
      end else begin
        s.attr = '0;
        s.pad_in[`BOARD_IO_MIO_JTAG_EN]  = 1'b0;
        s.pad_in[`BOARD_IO_MIO_USE_UPHY] = 1'b0;
        if (i < 24) begin
          s.drive.oe = '1;
          s.drive.oe[UsbDnPu] = 1'b0;
          s.pad_in[`BOARD_IO_MIO_JTAG_EN] = (i != 22);
          // TDO takes both values while the strap is high
          s.tdo = i[0];
        end else if (i < 28) begin
          s.drive.oe[UsbDnPu] = 1'b1;
        end else begin
          s.pad_in[`BOARD_IO_MIO_USE_UPHY] = 1'b1;
          s.drive.oe[UsbDnPu] = i[0];
        end
      end
      table_q[i].stim        = s;
      table_q[i].exp_now     = model_io(s, prev_strap);
      table_q[i].exp_settled = model_io(s, strap_of(s));
      prev_strap = strap_of(s);
    end
  endtask

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERR %s expected %0h actual %0h entry %0d", name, expected, actual, cur_entry);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs(input expect_t e, input bit settled);
    check_value("pad_out_o", pad_out_o, e.pad_out);
    check_value("pad_oe_o", pad_oe_o, e.pad_oe);
    check_value("uphy_tx", {uphy_dp_tx_o, uphy_dn_tx_o, uphy_oe_n_o, uphy_dppullup_o},
                e.uphy_tx);
    if (settled) begin
      check_value("core_in_o", core_in_o, e.core_in);
      check_value("jtag_o", jtag_o, e.jtag);
    end
  endtask

  initial begin
    rst_i        = 1'b1;
    core_drive_i = '0;
    core_attr_i  = '0;
    uphy_rx_i    = '1;
    jtag_tdo_i   = 1'b0;
    // All pads high during reset, strap and PHY switch included
    pad_in_i     = '1;
    build_table();
    repeat (4) @(negedge clk_main_i);
    rst_i = 1'b0;
    #1;
    check_value("core_in_o", core_in_o, '0);
    check_value("jtag_o", jtag_o, '0);
    // One edge later the pad values are still in the first stage
    @(negedge clk_main_i);
    check_value("core_in_o", core_in_o, '0);
    check_value("jtag_o", jtag_o, '0);
    for (int i = 0; i < NumEntries; i++) begin
      cur_entry    = i;
      core_drive_i = table_q[i].stim.drive;
      core_attr_i  = table_q[i].stim.attr;
      pad_in_i     = table_q[i].stim.pad_in;
      uphy_rx_i    = table_q[i].stim.uphy_rx;
      jtag_tdo_i   = table_q[i].stim.tdo;
      #1;
      check_outputs(table_q[i].exp_now, 1'b0);
      @(posedge clk_main_i);
      @(posedge clk_main_i);
      @(negedge clk_main_i);
      check_outputs(table_q[i].exp_settled, 1'b1);
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- usb_swap_mux.sv
////////////////////////////////////////
// USB swap mux
// Undoes the USB pin flip, selects the external PHY receive path
////////////////////////////////////////

`timescale 1ns/1ps

`include "board_io_defines.svh"

module usb_swap_mux (
  input  logic                            clk_main_i,
  input  logic                            rst_i,
  // Core side
  input  board_io_pkg::pad_drive_t        core_drive_i,
  output logic [`BOARD_IO_NUM_PADS-1:0]   core_in_o,
  // Towards the JTAG overlay
  output board_io_pkg::pad_drive_t        drive_o,
  input  logic [`BOARD_IO_NUM_PADS-1:0]   overlay_in_i,
  // External USB PHY
  input  board_io_pkg::uphy_rx_t          uphy_rx_i,
  output logic                            uphy_dp_tx_o,
  output logic                            uphy_dn_tx_o,
  output logic                            uphy_oe_n_o,
  output logic                            uphy_dppullup_o
);

  import board_io_pkg::*;

  localparam int SyncStages = `BOARD_IO_SYNC_STAGES;

  // USB pads in the combined pad index space
  localparam int DnIdx    = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DN;
  localparam int DpIdx    = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DP;
  localparam int DIdx     = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_D;
  localparam int DnPuIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DN_PULLUP;
  localparam int DpPuIdx  = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_DP_PULLUP;
  localparam int SenseIdx = `BOARD_IO_NUM_MIO + `BOARD_IO_DIO_USB_SENSE;

  uphy_rx_t [SyncStages-1:0] uphy_sync_q;
  uphy_rx_t                  rx_sel;
  pad_drive_t                swap_drive;
  logic                      undo_swap;
  logic                      use_uphy;

  // Core flips the pins whenever it enables the DN pull-up
  assign undo_swap = core_drive_i.oe[DnPuIdx];
  // Board switch, already synchronized by its pad cell
  assign use_uphy  = overlay_in_i[`BOARD_IO_MIO_USE_UPHY];

  ////////////////////////////////////////
  // Drive path
  ////////////////////////////////////////

  always_comb begin
    swap_drive = core_drive_i;
    if (undo_swap) begin
      swap_drive.out[DnIdx]   = core_drive_i.out[DpIdx];
      swap_drive.oe[DnIdx]    = core_drive_i.oe[DpIdx];
      swap_drive.out[DpIdx]   = core_drive_i.out[DnIdx];
      swap_drive.oe[DpIdx]    = core_drive_i.oe[DnIdx];
      swap_drive.out[DnPuIdx] = core_drive_i.out[DpPuIdx];
      swap_drive.oe[DnPuIdx]  = core_drive_i.oe[DpPuIdx];
      swap_drive.out[DpPuIdx] = core_drive_i.out[DnPuIdx];
      swap_drive.oe[DpPuIdx]  = core_drive_i.oe[DnPuIdx];
      // D polarity follows the flip
      swap_drive.out[DIdx]    = ~core_drive_i.out[DIdx];
    end
  end

  assign drive_o = swap_drive;

  // PHY transmit copies the unflipped pads
  assign uphy_dp_tx_o    = swap_drive.out[DpIdx];
  assign uphy_dn_tx_o    = swap_drive.out[DnIdx];
  assign uphy_oe_n_o     = ~swap_drive.oe[DpIdx];
  assign uphy_dppullup_o = swap_drive.out[DpPuIdx] & swap_drive.oe[DpPuIdx];

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  // PHY inputs bypass the pad cells, so they get their own synchronizer
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      uphy_sync_q <= '0;
    end else begin
      uphy_sync_q <= {uphy_sync_q[SyncStages-2:0], uphy_rx_i};
    end
  end

  always_comb begin
    if (use_uphy) begin
      rx_sel = uphy_sync_q[SyncStages-1];
    end else begin
      rx_sel = '{
        dp:    overlay_in_i[DpIdx],
        dn:    overlay_in_i[DnIdx],
        d:     overlay_in_i[DIdx],
        sense: overlay_in_i[SenseIdx]
      };
    end
  end

  always_comb begin
    core_in_o           = overlay_in_i;
    core_in_o[DnIdx]    = undo_swap ? rx_sel.dp : rx_sel.dn;
    core_in_o[DpIdx]    = undo_swap ? rx_sel.dn : rx_sel.dp;
    core_in_o[DIdx]     = rx_sel.d ^ undo_swap;
    core_in_o[SenseIdx] = rx_sel.sense;
  end

endmodule
